// ==== src/pcie_cfg_pkg.sv ====
// ----------------------------------------------------------
// shared widths, TLP type codes and completion status codes
// header field helpers and the completion header builder
// ----------------------------------------------------------
`default_nettype none

package pcie_cfg_pkg;

  typedef logic [31:0] dword_t;
  typedef logic [95:0] tlp_hdr_t;
  typedef logic [31:0] cfg_addr_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [1:0]  axil_resp_t;
  typedef logic [15:0] pcie_id_t;
  typedef logic [7:0]  tlp_tag_t;
  typedef logic [9:0]  reg_num_t;

  typedef enum logic [2:0] {
    cpl_sc = 3'd0,
    cpl_ur = 3'd1
  } cpl_status_t;

  // fmt/type byte, bits [31:24] of header dword 0
  localparam logic [7:0] cfg_rd0    = 8'h04;
  localparam logic [7:0] cfg_wr0    = 8'h44;
  localparam logic [7:0] cpl_nodata = 8'h0A;
  localparam logic [7:0] cpl_data   = 8'h4A;

  localparam axil_resp_t axil_okay   = 2'b00;
  localparam axil_resp_t axil_slverr = 2'b10;

  function automatic logic [7:0] hdr_fmt_type(tlp_hdr_t hdr);
    return hdr[31:24];
  endfunction

  function automatic pcie_id_t hdr_req_id(tlp_hdr_t hdr);
    return hdr[63:48];
  endfunction

  function automatic tlp_tag_t hdr_tag(tlp_hdr_t hdr);
    return hdr[47:40];
  endfunction

  function automatic byte_en_t hdr_first_be(tlp_hdr_t hdr);
    return hdr[35:32];
  endfunction

  // register number sits in dword 2, above the two reserved bits
  function automatic reg_num_t hdr_reg_num(tlp_hdr_t hdr);
    return hdr[75:66];
  endfunction

  // byte count is always one dword, lower address is always 0
  function automatic tlp_hdr_t build_cpl_hdr(pcie_id_t req_id, tlp_tag_t tag,
                                             pcie_id_t cpl_id, cpl_status_t status,
                                             logic with_data);
    dword_t dw0;
    dword_t dw1;
    dword_t dw2;
    dw0 = {(with_data ? cpl_data : cpl_nodata), 14'd0, (with_data ? 10'd1 : 10'd0)};
    dw1 = {cpl_id, status, 1'b0, 12'd4};
    dw2 = {req_id, tag, 8'h00};
    return {dw2, dw1, dw0};
  endfunction

endpackage

`default_nettype wire

// ==== src/axil_if.sv ====
// ----------------------------------------------------------
// AXI4-Lite bus with master and slave modports
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface axil_if import pcie_cfg_pkg::*; ();

  logic       awvalid;
  logic       awready;
  cfg_addr_t  awaddr;
  logic       wvalid;
  logic       wready;
  dword_t     wdata;
  byte_en_t   wstrb;
  logic       bvalid;
  logic       bready;
  axil_resp_t bresp;
  logic       arvalid;
  logic       arready;
  cfg_addr_t  araddr;
  logic       rvalid;
  logic       rready;
  dword_t     rdata;
  axil_resp_t rresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

`default_nettype wire

// ==== src/axis_skid_buffer.sv ====
// ----------------------------------------------------------
// two-entry skid buffer for an AXI4-Stream with keep and last
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module axis_skid_buffer #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [DATA_WIDTH-1:0]   s_tdata,
  input  logic [DATA_WIDTH/8-1:0] s_tkeep,
  input  logic                    s_tvalid,
  input  logic                    s_tlast,
  output logic                    s_tready,
  output logic [DATA_WIDTH-1:0]   m_tdata,
  output logic [DATA_WIDTH/8-1:0] m_tkeep,
  output logic                    m_tvalid,
  output logic                    m_tlast,
  input  logic                    m_tready
);

  logic [DATA_WIDTH-1:0]   skid_tdata;
  logic [DATA_WIDTH/8-1:0] skid_tkeep;
  logic                    skid_tlast;
  logic                    skid_valid;
  logic                    out_load;

  // input side only sees whether the skid slot is taken
  assign s_tready = ~skid_valid;
  assign out_load = m_tready | ~m_tvalid;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      m_tvalid   <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_load) begin
      m_tvalid   <= skid_valid | s_tvalid;
      skid_valid <= 1'b0;
    end else if (s_tvalid && s_tready) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_load) begin
      m_tdata <= skid_valid ? skid_tdata : s_tdata;
      m_tkeep <= skid_valid ? skid_tkeep : s_tkeep;
      m_tlast <= skid_valid ? skid_tlast : s_tlast;
    end else if (s_tvalid && s_tready) begin
      skid_tdata <= s_tdata;
      skid_tkeep <= s_tkeep;
      skid_tlast <= s_tlast;
    end
  end

  // a word refused while the skid slot is full must be held at the input
  assert property (@(posedge clk_i) disable iff (rst_i)
    s_tvalid && !s_tready |=> s_tvalid && $stable(s_tdata) && $stable(s_tlast));

endmodule

`default_nettype wire

// ==== src/pcie_cfg_handler.sv ====
// ----------------------------------------------------------
// type 0 config TLP decoder and AXI4-Lite master
// builds the Cpl/CplD and streams it one dword per beat
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module pcie_cfg_handler
  import pcie_cfg_pkg::*;
#(
  parameter int       NUM_REGS     = 16,
  parameter pcie_id_t COMPLETER_ID = 16'h0100
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  tlp_hdr_t    rx_tlp_hdr,
  input  dword_t      rx_tlp_data,
  input  logic        rx_tlp_valid,
  input  logic        rx_tlp_sop,
  input  logic        rx_tlp_eop,
  output logic        rx_tlp_ready,
  axil_if.master      axil,
  output dword_t      s_tdata,
  output logic [3:0]  s_tkeep,
  output logic        s_tvalid,
  output logic        s_tlast,
  input  logic        s_tready
);

  typedef enum logic [2:0] {
    st_idle,
    st_wr,
    st_wr_resp,
    st_rd_addr,
    st_rd_data,
    st_send
  } state_t;

  state_t      state;
  logic        aw_done_q;
  logic        w_done_q;
  logic        aw_done;
  logic        w_done;
  logic [1:0]  word_cnt;
  logic [7:0]  req_type;
  pcie_id_t    req_id_q;
  tlp_tag_t    tag_q;
  cfg_addr_t   addr_q;
  dword_t      wdata_q;
  byte_en_t    wstrb_q;
  tlp_hdr_t    cpl_hdr_q;
  dword_t      rdata_q;
  logic        has_data_q;
  cpl_status_t b_status;
  cpl_status_t r_status;

  assign req_type     = hdr_fmt_type(rx_tlp_hdr);
  assign rx_tlp_ready = (state == st_idle);

  assign axil.awvalid = (state == st_wr) && !aw_done_q;
  assign axil.awaddr  = addr_q;
  assign axil.wvalid  = (state == st_wr) && !w_done_q;
  assign axil.wdata   = wdata_q;
  assign axil.wstrb   = wstrb_q;
  assign axil.bready  = (state == st_wr_resp);
  assign axil.arvalid = (state == st_rd_addr);
  assign axil.araddr  = addr_q;
  assign axil.rready  = (state == st_rd_data);

  // AW and W may land on different cycles
  assign aw_done = aw_done_q | (axil.awvalid & axil.awready);
  assign w_done  = w_done_q | (axil.wvalid & axil.wready);

  // any error response is reported as unsupported request
  assign b_status = (axil.bresp == axil_okay) ? cpl_sc : cpl_ur;
  assign r_status = (axil.rresp == axil_okay) ? cpl_sc : cpl_ur;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state     <= st_idle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      word_cnt  <= 2'd0;
    end else begin
      case (state)
        st_idle: begin
          // anything but CfgRd0/CfgWr0 is swallowed here
          if (rx_tlp_valid && rx_tlp_sop && rx_tlp_eop) begin
            if (req_type == cfg_rd0) begin
              state <= st_rd_addr;
            end else if (req_type == cfg_wr0) begin
              state <= st_wr;
            end
          end
        end
        st_wr: begin
          if (aw_done && w_done) begin
            state     <= st_wr_resp;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end else begin
            aw_done_q <= aw_done;
            w_done_q  <= w_done;
          end
        end
        st_wr_resp: begin
          if (axil.bvalid) begin
            state    <= st_send;
            word_cnt <= 2'd0;
          end
        end
        st_rd_addr: begin
          if (axil.arready) begin
            state <= st_rd_data;
          end
        end
        st_rd_data: begin
          if (axil.rvalid) begin
            state    <= st_send;
            word_cnt <= 2'd0;
          end
        end
        st_send: begin
          if (s_tready) begin
            word_cnt <= word_cnt + 2'd1;
            if (s_tlast) begin
              state <= st_idle;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_tlp_valid && rx_tlp_ready) begin
      req_id_q <= hdr_req_id(rx_tlp_hdr);
      tag_q    <= hdr_tag(rx_tlp_hdr);
      addr_q   <= {20'd0, hdr_reg_num(rx_tlp_hdr), 2'b00};
      wdata_q  <= rx_tlp_data;
      wstrb_q  <= hdr_first_be(rx_tlp_hdr);
    end
    if (axil.bvalid && axil.bready) begin
      cpl_hdr_q  <= build_cpl_hdr(req_id_q, tag_q, COMPLETER_ID, b_status, 1'b0);
      has_data_q <= 1'b0;
    end
    if (axil.rvalid && axil.rready) begin
      cpl_hdr_q  <= build_cpl_hdr(req_id_q, tag_q, COMPLETER_ID, r_status,
                                  r_status == cpl_sc);
      has_data_q <= (r_status == cpl_sc);
      rdata_q    <= axil.rdata;
    end
  end

  // header dwords first, then the read value for a CplD
  always_comb begin
    case (word_cnt)
      2'd0:    s_tdata = cpl_hdr_q[31:0];
      2'd1:    s_tdata = cpl_hdr_q[63:32];
      2'd2:    s_tdata = cpl_hdr_q[95:64];
      default: s_tdata = rdata_q;
    endcase
  end

  assign s_tkeep  = 4'hF;
  assign s_tvalid = (state == st_send);
  assign s_tlast  = s_tvalid && (word_cnt == (has_data_q ? 2'd3 : 2'd2));

  assert property (@(posedge clk_i) disable iff (rst_i)
    axil.awvalid && !axil.awready |=> axil.awvalid && $stable(axil.awaddr));
  assert property (@(posedge clk_i) disable iff (rst_i)
    axil.wvalid && !axil.wready |=> axil.wvalid && $stable(axil.wdata));
  assert property (@(posedge clk_i) disable iff (rst_i)
    axil.arvalid && !axil.arready |=> axil.arvalid && $stable(axil.araddr));

  // nothing follows the last word of a completion
  assert property (@(posedge clk_i) disable iff (rst_i)
    s_tvalid && s_tready && s_tlast |=> !s_tvalid);

  // the register space refuses exactly the registers beyond its size
  assert property (@(posedge clk_i) disable iff (rst_i)
    axil.rvalid && axil.rready |->
      (axil.rresp != axil_okay) == (addr_q[31:2] >= 30'(NUM_REGS)));

endmodule

`default_nettype wire

// ==== src/cfg_space_regs.sv ====
// ----------------------------------------------------------
// AXI4-Lite slave with the configuration dword registers
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module cfg_space_regs
  import pcie_cfg_pkg::*;
#(
  parameter int     NUM_REGS = 16,
  parameter dword_t ID_VALUE = 32'h1234_10EE
) (
  input  logic   clk_i,
  input  logic   rst_i,
  axil_if.slave  axil
);

  localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

  dword_t    regs [NUM_REGS];
  logic      aw_got;
  logic      w_got;
  cfg_addr_t aw_addr_q;
  dword_t    w_data_q;
  byte_en_t  w_strb_q;
  logic      aw_done;
  logic      w_done;
  cfg_addr_t wr_addr;
  dword_t    wr_data;
  byte_en_t  wr_strb;
  logic      wr_ok;
  logic      rd_ok;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  assign axil.awready = !aw_got && !axil.bvalid;
  assign axil.wready  = !w_got && !axil.bvalid;
  assign axil.arready = !axil.rvalid;

  assign aw_done = aw_got | (axil.awvalid & axil.awready);
  assign w_done  = w_got | (axil.wvalid & axil.wready);

  // take the held half when AW and W arrived apart
  assign wr_addr = aw_got ? aw_addr_q : axil.awaddr;
  assign wr_data = w_got ? w_data_q : axil.wdata;
  assign wr_strb = w_got ? w_strb_q : axil.wstrb;

  assign wr_ok  = wr_addr[31:2] < 30'(NUM_REGS);
  assign rd_ok  = axil.araddr[31:2] < 30'(NUM_REGS);
  assign wr_idx = wr_addr[IDX_W+1:2];
  assign rd_idx = axil.araddr[IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_got      <= 1'b0;
      w_got       <= 1'b0;
      axil.bvalid <= 1'b0;
      axil.rvalid <= 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        // register 0 is the fixed ID and is never written
        regs[i] <= (i == 0) ? ID_VALUE : '0;
      end
    end else begin
      if (aw_done && w_done && !axil.bvalid) begin
        aw_got      <= 1'b0;
        w_got       <= 1'b0;
        axil.bvalid <= 1'b1;
        if (wr_ok && wr_idx != '0) begin
          for (int b = 0; b < 4; b++) begin
            if (wr_strb[b]) begin
              regs[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
            end
          end
        end
      end else begin
        aw_got <= aw_done;
        w_got  <= w_done;
        if (axil.bvalid && axil.bready) begin
          axil.bvalid <= 1'b0;
        end
      end
      if (axil.arvalid && axil.arready) begin
        axil.rvalid <= 1'b1;
      end else if (axil.rvalid && axil.rready) begin
        axil.rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (axil.awvalid && axil.awready) begin
      aw_addr_q <= axil.awaddr;
    end
    if (axil.wvalid && axil.wready) begin
      w_data_q <= axil.wdata;
      w_strb_q <= axil.wstrb;
    end
    if (aw_done && w_done && !axil.bvalid) begin
      axil.bresp <= wr_ok ? axil_okay : axil_slverr;
    end
    if (axil.arvalid && axil.arready) begin
      axil.rdata <= rd_ok ? regs[rd_idx] : '0;
      axil.rresp <= rd_ok ? axil_okay : axil_slverr;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(axil.bvalid) |-> $past(aw_done && w_done));

  // register 0 reads back the fixed ID whatever was written to it
  assert property (@(posedge clk_i) disable iff (rst_i)
    axil.arvalid && axil.arready && axil.araddr[31:2] == 30'd0 |=> axil.rdata == ID_VALUE);

endmodule

`default_nettype wire

// ==== src/pcie_cfg_top.sv ====
// ----------------------------------------------------------
// config request path top level
// handler, register space and completion skid buffer
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module pcie_cfg_top
  import pcie_cfg_pkg::*;
#(
  parameter int       NUM_REGS     = 16,
  parameter pcie_id_t COMPLETER_ID = 16'h0100,
  parameter dword_t   ID_VALUE     = 32'h1234_10EE
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  tlp_hdr_t   rx_tlp_hdr,
  input  dword_t     rx_tlp_data,
  input  logic       rx_tlp_valid,
  input  logic       rx_tlp_sop,
  input  logic       rx_tlp_eop,
  output logic       rx_tlp_ready,
  output dword_t     cpl_tdata,
  output logic [3:0] cpl_tkeep,
  output logic       cpl_tvalid,
  output logic       cpl_tlast,
  input  logic       cpl_tready
);

  axil_if axil ();

  // completion stream from the handler into the skid buffer
  dword_t     s_tdata;
  logic [3:0] s_tkeep;
  logic       s_tvalid;
  logic       s_tlast;
  logic       s_tready;

  pcie_cfg_handler #(
    .NUM_REGS     (NUM_REGS),
    .COMPLETER_ID (COMPLETER_ID)
  ) u_handler (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rx_tlp_hdr   (rx_tlp_hdr),
    .rx_tlp_data  (rx_tlp_data),
    .rx_tlp_valid (rx_tlp_valid),
    .rx_tlp_sop   (rx_tlp_sop),
    .rx_tlp_eop   (rx_tlp_eop),
    .rx_tlp_ready (rx_tlp_ready),
    .axil         (axil.master),
    .s_tdata      (s_tdata),
    .s_tkeep      (s_tkeep),
    .s_tvalid     (s_tvalid),
    .s_tlast      (s_tlast),
    .s_tready     (s_tready)
  );

  cfg_space_regs #(
    .NUM_REGS (NUM_REGS),
    .ID_VALUE (ID_VALUE)
  ) u_regs (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .axil  (axil.slave)
  );

  axis_skid_buffer #(
    .DATA_WIDTH (32)
  ) u_cpl_skid (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tvalid (s_tvalid),
    .s_tlast  (s_tlast),
    .s_tready (s_tready),
    .m_tdata  (cpl_tdata),
    .m_tkeep  (cpl_tkeep),
    .m_tvalid (cpl_tvalid),
    .m_tlast  (cpl_tlast),
    .m_tready (cpl_tready)
  );

endmodule

`default_nettype wire

// ==== tb/tb_pcie_cfg_top.sv ====
// ----------------------------------------------------------
// table-driven testbench for the config request path
// completion collector, register model and back-pressure
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_pcie_cfg_top import pcie_cfg_pkg::*; ();

  localparam int       NUM_REGS       = 16;
  localparam pcie_id_t COMPLETER_ID   = 16'h0100;
  localparam dword_t   ID_VALUE       = 32'h1234_10EE;
  localparam int       NUM_ROWS       = 17;
  localparam int       TIMEOUT_CYCLES = NUM_ROWS * 60 + 200;

  logic       clk_i = 1'b0;
  logic       rst_i;
  tlp_hdr_t   rx_tlp_hdr;
  dword_t     rx_tlp_data;
  logic       rx_tlp_valid;
  logic       rx_tlp_sop;
  logic       rx_tlp_eop;
  logic       rx_tlp_ready;
  dword_t     cpl_tdata;
  logic [3:0] cpl_tkeep;
  logic       cpl_tvalid;
  logic       cpl_tlast;
  logic       cpl_tready;

  // stimulus table, one request per row
  string       row_name  [NUM_ROWS];
  logic [7:0]  row_fmt   [NUM_ROWS];
  reg_num_t    row_reg   [NUM_ROWS];
  byte_en_t    row_be    [NUM_ROWS];
  dword_t      row_data  [NUM_ROWS];
  cpl_status_t row_status[NUM_ROWS];
  dword_t      row_rdata [NUM_ROWS];

  dword_t     model [NUM_REGS];
  dword_t     word_q [$];
  logic [3:0] keep_q [$];
  logic       last_q [$];
  int         cpl_count = 0;
  int         cycle_cnt;
  integer     seed;
  int         rnd;

  pcie_cfg_top #(
    .NUM_REGS     (NUM_REGS),
    .COMPLETER_ID (COMPLETER_ID),
    .ID_VALUE     (ID_VALUE)
  ) UUT (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rx_tlp_hdr   (rx_tlp_hdr),
    .rx_tlp_data  (rx_tlp_data),
    .rx_tlp_valid (rx_tlp_valid),
    .rx_tlp_sop   (rx_tlp_sop),
    .rx_tlp_eop   (rx_tlp_eop),
    .rx_tlp_ready (rx_tlp_ready),
    .cpl_tdata    (cpl_tdata),
    .cpl_tkeep    (cpl_tkeep),
    .cpl_tvalid   (cpl_tvalid),
    .cpl_tlast    (cpl_tlast),
    .cpl_tready   (cpl_tready)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_value(input string test, input string what,
                             input dword_t exp, input dword_t act);
    if (exp !== act) begin
      $display("** Error: %s %s expected %h actual %h", test, what, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic set_row(input int idx, input string name, input logic [7:0] fmt,
                         input reg_num_t reg_n, input byte_en_t be, input dword_t data,
                         input cpl_status_t st, input dword_t rdata);
    row_name[idx]   = name;
    row_fmt[idx]    = fmt;
    row_reg[idx]    = reg_n;
    row_be[idx]     = be;
    row_data[idx]   = data;
    row_status[idx] = st;
    row_rdata[idx]  = rdata;
  endtask

  // 3DW request, length 1, register number in dword 2 [11:2]
  function automatic tlp_hdr_t make_request_hdr(input logic [7:0] fmt, input pcie_id_t req_id,
                                                input tlp_tag_t tag, input byte_en_t be,
                                                input reg_num_t reg_n);
    dword_t dw0;
    dword_t dw1;
    dword_t dw2;
    dw0 = {fmt, 14'd0, 10'd1};
    dw1 = {req_id, tag, 4'h0, be};
    dw2 = {16'h0000, 4'h0, reg_n, 2'b00};
    return {dw2, dw1, dw0};
  endfunction

  // header dword k of a Cpl or CplD, one dword of byte count
  function automatic dword_t expected_cpl_word(input int k, input pcie_id_t req_id,
                                               input tlp_tag_t tag, input cpl_status_t st,
                                               input logic with_data);
    dword_t w;
    w = 32'h0;
    case (k)
      0: begin
        w[31:24] = with_data ? 8'h4A : 8'h0A;
        w[9:0]   = with_data ? 10'd1 : 10'd0;
      end
      1: begin
        w[31:16] = COMPLETER_ID;
        w[15:13] = st;
        w[11:0]  = 12'd4;
      end
      default: begin
        w[31:16] = req_id;
        w[15:8]  = tag;
      end
    endcase
    return w;
  endfunction

  // called a little after a clock edge, returns the same way
  task automatic send_request(input logic [7:0] fmt, input pcie_id_t req_id,
                              input tlp_tag_t tag, input byte_en_t be,
                              input reg_num_t reg_n, input dword_t data);
    rx_tlp_hdr   = make_request_hdr(fmt, req_id, tag, be, reg_n);
    rx_tlp_data  = data;
    rx_tlp_valid = 1'b1;
    rx_tlp_sop   = 1'b1;
    rx_tlp_eop   = 1'b1;
    while (!rx_tlp_ready) begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    rx_tlp_valid = 1'b0;
    rx_tlp_sop   = 1'b0;
    rx_tlp_eop   = 1'b0;
  endtask

  // collects every completion word taken at the output
  always @(posedge clk_i) begin
    if (!rst_i && cpl_tvalid && cpl_tready) begin
      word_q.push_back(cpl_tdata);
      keep_q.push_back(cpl_tkeep);
      last_q.push_back(cpl_tlast);
      if (cpl_tlast) begin
        cpl_count = cpl_count + 1;
      end
    end
  end

  // random back-pressure on the completion stream
  initial begin
    seed       = 32'hc90f;
    cpl_tready = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      rnd        = $random(seed);
      cpl_tready = rnd[0];
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("timeout: the requests did not finish within %0d cycles", cycle_cnt);
    $display("TESTS FAILED");
    $fatal(1, "simulation timed out");
  end

  initial begin
    int          idx;
    int          rd_ptr;
    int          done_cnt;
    int          n;
    logic        is_cfg;
    logic        is_rd;
    int          exp_words;
    cpl_status_t exp_status;
    dword_t      exp_data;
    dword_t      exp_w;
    pcie_id_t    req_id;
    tlp_tag_t    tag;

    rst_i        = 1'b1;
    rx_tlp_hdr   = '0;
    rx_tlp_data  = '0;
    rx_tlp_valid = 1'b0;
    rx_tlp_sop   = 1'b0;
    rx_tlp_eop   = 1'b0;
    rd_ptr       = 0;
    done_cnt     = 0;

    set_row(0,  "rd_id",        cfg_rd0, 10'd0,    4'hF, 32'h0,         cpl_sc, ID_VALUE);
    set_row(1,  "wr_id",        cfg_wr0, 10'd0,    4'hF, 32'hDEAD_BEEF, cpl_sc, 32'h0);
    set_row(2,  "rd_id_again",  cfg_rd0, 10'd0,    4'hF, 32'h0,         cpl_sc, ID_VALUE);
    set_row(3,  "wr_r5",        cfg_wr0, 10'd5,    4'hF, 32'hA5A5_5A5A, cpl_sc, 32'h0);
    set_row(4,  "rd_r5",        cfg_rd0, 10'd5,    4'hF, 32'h0,         cpl_sc, 32'hA5A5_5A5A);
    set_row(5,  "wr_r5_part",   cfg_wr0, 10'd5,    4'h5, 32'h1122_3344, cpl_sc, 32'h0);
    set_row(6,  "rd_r5_part",   cfg_rd0, 10'd5,    4'hF, 32'h0,         cpl_sc, 32'hA522_5A44);
    set_row(7,  "wr_r15",       cfg_wr0, 10'd15,   4'hF, 32'h0F0F_F0F0, cpl_sc, 32'h0);
    set_row(8,  "wr_oor",       cfg_wr0, 10'd21,   4'hF, 32'hFFFF_FFFF, cpl_ur, 32'h0);
    set_row(9,  "rd_oor",       cfg_rd0, 10'd20,   4'hF, 32'h0,         cpl_ur, 32'h0);
    set_row(10, "rd_r15",       cfg_rd0, 10'd15,   4'hF, 32'h0,         cpl_sc, 32'h0F0F_F0F0);
    set_row(11, "mwr_drop",     8'h40,   10'd5,    4'hF, 32'h0BAD_0BAD, cpl_sc, 32'h0);
    set_row(12, "rd_r5_after",  cfg_rd0, 10'd5,    4'hF, 32'h0,         cpl_sc, 32'hA522_5A44);
    set_row(13, "rd_r3",        cfg_rd0, 10'd3,    4'hF, 32'h0,         cpl_sc, 32'h0);
    set_row(14, "wr_r3_hi",     cfg_wr0, 10'd3,    4'h8, 32'h8899_AABB, cpl_sc, 32'h0);
    set_row(15, "rd_r3_hi",     cfg_rd0, 10'd3,    4'hF, 32'h0,         cpl_sc, 32'h8800_0000);
    set_row(16, "rd_r1023",     cfg_rd0, 10'd1023, 4'hF, 32'h0,         cpl_ur, 32'h0);

    // register 0 holds the ID, the rest clear at reset
    for (int r = 0; r < NUM_REGS; r++) begin
      model[r] = (r == 0) ? ID_VALUE : 32'h0;
    end

    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_value("reset", "rx_tlp_ready", 32'h1, 32'(rx_tlp_ready));
    check_value("reset", "cpl_tvalid", 32'h0, 32'(cpl_tvalid));

    for (int i = 0; i < NUM_ROWS; i++) begin
      idx        = int'(row_reg[i]);
      is_rd      = (row_fmt[i] == cfg_rd0);
      is_cfg     = is_rd || (row_fmt[i] == cfg_wr0);
      exp_status = (idx < NUM_REGS) ? cpl_sc : cpl_ur;
      exp_data   = (is_rd && idx < NUM_REGS) ? model[idx] : 32'h0;
      exp_words  = (is_rd && exp_status == cpl_sc) ? 4 : 3;
      req_id     = pcie_id_t'(16'hA000 + i);
      tag        = tlp_tag_t'(i + 1);

      // the table must agree with the register rules
      if (is_cfg) begin
        check_value(row_name[i], "model status", 32'(exp_status), 32'(row_status[i]));
        check_value(row_name[i], "model data", exp_data, row_rdata[i]);
      end
      check_value(row_name[i], "stray words", 32'(rd_ptr), 32'(word_q.size()));

      send_request(row_fmt[i], req_id, tag, row_be[i], row_reg[i], row_data[i]);

      if (is_cfg) begin
        while (cpl_count == done_cnt) begin
          @(posedge clk_i);
          #1;
        end
        done_cnt = done_cnt + 1;
        n        = word_q.size() - rd_ptr;
        check_value(row_name[i], "word count", 32'(exp_words), 32'(n));
        for (int k = 0; k < n; k++) begin
          exp_w = (k < 3) ? expected_cpl_word(k, req_id, tag, exp_status, exp_words == 4)
                          : row_rdata[i];
          check_value(row_name[i], $sformatf("word %0d", k), exp_w, word_q[rd_ptr + k]);
          check_value(row_name[i], "tkeep", 32'hF, 32'(keep_q[rd_ptr + k]));
          check_value(row_name[i], "tlast", (k == n - 1) ? 32'h1 : 32'h0,
                      32'(last_q[rd_ptr + k]));
        end
        rd_ptr = word_q.size();
      end else begin
        // a dropped TLP must leave the completion stream silent
        repeat (20) @(posedge clk_i);
        #1;
        check_value(row_name[i], "no completion", 32'(rd_ptr), 32'(word_q.size()));
      end

      if (row_fmt[i] == cfg_wr0 && idx > 0 && idx < NUM_REGS) begin
        for (int b = 0; b < 4; b++) begin
          if (row_be[i][b]) begin
            model[idx][8*b +: 8] = row_data[i][8*b +: 8];
          end
        end
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
src/pcie_cfg_pkg.sv
src/axil_if.sv
src/axis_skid_buffer.sv
src/pcie_cfg_handler.sv
src/cfg_space_regs.sv
src/pcie_cfg_top.sv
tb/tb_pcie_cfg_top.sv

// ==== run.sh ====
#!/bin/sh
# compile the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sources.f \
  --top-module tb_pcie_cfg_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
